//--- Makefile
VERILATOR  := verilator
TOP        := tb_sec_mem_subsys
FILE_LIST  := files.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert
OBJ_DIR    := obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

# the run passes only if the testbench prints the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

//--- files.f
+incdir+.
sec_mem_pkg.sv
mem_bank.sv
resp_queue.sv
proc_resp_acc.sv
sec_mem_subsys.sv
tb_sec_mem_subsys.sv

//--- mem_bank.sv
// tagged word memory with a one-entry response register
// a request is taken whenever the register is empty or being drained
`timescale 1ns/1ps
`include "sec_mem_consts.svh"

module mem_bank import sec_mem_pkg::*; (
	input  logic          clk,
	input  logic          rst,
	// processor request
	input  logic          req_val,
	output logic          req_rdy,
	input  mem_msg_type_t req_type,
	input  addr_t         req_addr,
	input  data_t         req_data,
	input  opaque_t       req_opaque,
	input  sec_level_t    proc_sec_level,
	// response toward the queue
	output logic          mresp_val,
	input  logic          mresp_rdy,
	output mem_msg_type_t mresp_type,
	output opaque_t       mresp_opaque,
	output data_t         mresp_data,
	output logic          mresp_fail,
	output sec_level_t    mresp_sec_level
);
	// data words and one security tag per word
	data_t      mem_data [`SEC_MEM_WORDS];
	sec_level_t mem_tag  [`SEC_MEM_WORDS];

	logic [`SEC_MEM_IDX_NBITS-1:0] idx;
	logic req_go;
	logic addr_ok;
	logic write_down;
	logic do_write;

	// ====================
	// request decode
	// ====================

	// register free now or emptied on this edge
	assign req_rdy = !mresp_val || mresp_rdy;
	assign req_go  = req_val && req_rdy;

	// word index drops the byte offset
	assign idx = req_addr[`SEC_MEM_IDX_NBITS+1:2];
	// inside the bank and word aligned
	assign addr_ok = (req_addr < addr_t'(`SEC_MEM_WORDS * 4)) && (req_addr[1:0] == 2'b00);

	// low writer hitting a high word
	assign write_down = (req_type == msg_write) && !proc_sec_level && mem_tag[idx];
	assign do_write   = req_go && addr_ok && (req_type == msg_write) && !write_down;

	// ====================
	// storage
	// ====================

	// memory starts all zero with every tag low
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `SEC_MEM_WORDS; i++) begin
				mem_data[i] <= '0;
				mem_tag[i]  <= 1'b0;
			end
		end else if (do_write) begin
			mem_data[idx] <= req_data;
			// word takes the level of its writer
			mem_tag[idx]  <= proc_sec_level;
		end
	end

	// ====================
	// response register
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			mresp_val <= 1'b0;
		end else if (req_go) begin
			mresp_val <= 1'b1;
		end else if (mresp_rdy) begin
			mresp_val <= 1'b0;
		end
	end

	// payload loads only on accept
	always_ff @(posedge clk) begin
		if (req_go) begin
			mresp_type   <= req_type;
			mresp_opaque <= req_opaque;
			if (!addr_ok) begin
				// bad address reports low with no data
				mresp_data      <= '0;
				mresp_fail      <= 1'b1;
				mresp_sec_level <= 1'b0;
			end else if (req_type == msg_read) begin
				mresp_data      <= mem_data[idx];
				mresp_fail      <= 1'b0;
				mresp_sec_level <= mem_tag[idx];
			end else if (write_down) begin
				// refused write keeps the tag of the protected word
				mresp_data      <= '0;
				mresp_fail      <= 1'b1;
				mresp_sec_level <= mem_tag[idx];
			end else begin
				mresp_data      <= '0;
				mresp_fail      <= 1'b0;
				mresp_sec_level <= proc_sec_level;
			end
		end
	end

	// a stalled response stays put until the queue takes it
	a_mresp_hold: assert property (@(posedge clk) disable iff (rst)
		mresp_val && !mresp_rdy |=> mresp_val && $stable(mresp_type) && $stable(mresp_opaque)
			&& $stable(mresp_data) && $stable(mresp_fail) && $stable(mresp_sec_level))
		else $error("mem_bank response changed while stalled");

endmodule

//--- proc_resp_acc.sv
// response access filter in front of the processor
// hides data of high words from a low processor but keeps the transaction
`timescale 1ns/1ps
`include "sec_mem_consts.svh"

module proc_resp_acc import sec_mem_pkg::*; (
	input  logic          clk,
	input  logic          rst,
	// queued response
	input  logic          qresp_val,
	output logic          qresp_rdy,
	input  mem_msg_type_t qresp_type,
	input  opaque_t       qresp_opaque,
	input  data_t         qresp_data,
	input  logic          qresp_fail,
	input  sec_level_t    qresp_sec_level,
	// current processor level
	input  sec_level_t    proc_sec_level,
	// toward the processor
	output logic          proc_resp_val,
	input  logic          proc_resp_rdy,
	output mem_msg_type_t proc_resp_type,
	output opaque_t       proc_resp_opaque,
	output data_t         proc_resp_data,
	output logic          proc_resp_fail
);
	logic read_up;

	// response is high and the processor is low
	assign read_up = qresp_sec_level && !proc_sec_level;

	// ====================
	// filter
	// ====================

	always_comb begin
		// handshake passes straight through on every path
		proc_resp_val    = qresp_val;
		qresp_rdy        = proc_resp_rdy;
		proc_resp_type   = qresp_type;
		proc_resp_opaque = qresp_opaque;
		if (read_up) begin
			// drop the data and flag the access
			proc_resp_data = '0;
			proc_resp_fail = 1'b1;
		end else begin
			// same level, or low response seen by a high processor
			proc_resp_data = qresp_data;
			proc_resp_fail = qresp_fail;
		end
	end

	// nothing high ever reaches a low processor
	a_no_leak: assert property (@(posedge clk) disable iff (rst)
		proc_resp_val && proc_resp_rdy && qresp_sec_level && !proc_sec_level
			|-> proc_resp_fail && (proc_resp_data == '0))
		else $error("proc_resp_acc delivered high data to a low processor");

endmodule

//--- resp_queue.sv
// circular response queue between the bank and the access filter
// a pushed entry shows at the output one cycle later, no bypass path
`timescale 1ns/1ps
`include "sec_mem_consts.svh"

module resp_queue import sec_mem_pkg::*; (
	input  logic          clk,
	input  logic          rst,
	// from the bank
	input  logic          mresp_val,
	output logic          mresp_rdy,
	input  mem_msg_type_t mresp_type,
	input  opaque_t       mresp_opaque,
	input  data_t         mresp_data,
	input  logic          mresp_fail,
	input  sec_level_t    mresp_sec_level,
	// toward the filter
	output logic          qresp_val,
	input  logic          qresp_rdy,
	output mem_msg_type_t qresp_type,
	output opaque_t       qresp_opaque,
	output data_t         qresp_data,
	output logic          qresp_fail,
	output sec_level_t    qresp_sec_level
);
	// entry storage
	mem_msg_type_t q_type   [`SEC_MEM_QUEUE_DEPTH];
	opaque_t       q_opaque [`SEC_MEM_QUEUE_DEPTH];
	data_t         q_data   [`SEC_MEM_QUEUE_DEPTH];
	logic          q_fail   [`SEC_MEM_QUEUE_DEPTH];
	sec_level_t    q_level  [`SEC_MEM_QUEUE_DEPTH];

	q_ptr_t wr_ptr;
	q_ptr_t rd_ptr;
	logic [$clog2(`SEC_MEM_QUEUE_DEPTH+1)-1:0] count;
	logic push;
	logic pop;

	// ====================
	// handshakes
	// ====================

	assign mresp_rdy = (count != `SEC_MEM_QUEUE_DEPTH);
	assign qresp_val = (count != 0);
	assign push = mresp_val && mresp_rdy;
	assign pop  = qresp_val && qresp_rdy;

	// head entry
	assign qresp_type      = q_type[rd_ptr];
	assign qresp_opaque    = q_opaque[rd_ptr];
	assign qresp_data      = q_data[rd_ptr];
	assign qresp_fail      = q_fail[rd_ptr];
	assign qresp_sec_level = q_level[rd_ptr];

	// ====================
	// pointers and count
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == q_ptr_t'(`SEC_MEM_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == q_ptr_t'(`SEC_MEM_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// push and pop together leave the count alone
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			q_type[wr_ptr]   <= mresp_type;
			q_opaque[wr_ptr] <= mresp_opaque;
			q_data[wr_ptr]   <= mresp_data;
			q_fail[wr_ptr]   <= mresp_fail;
			q_level[wr_ptr]  <= mresp_sec_level;
		end
	end

	// full queue never overwrites an entry
	a_no_push_full: assert property (@(posedge clk) disable iff (rst)
		(count == `SEC_MEM_QUEUE_DEPTH) |=> $stable(wr_ptr))
		else $error("resp_queue pushed while full");

	// empty queue never hands out an entry
	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
		(count == 0) |=> $stable(rd_ptr))
		else $error("resp_queue popped while empty");

endmodule

//--- sec_mem_consts.svh
// width, depth and size constants for the security memory subsystem
// include wherever a field width or a memory size is needed
`ifndef SEC_MEM_CONSTS_SVH
`define SEC_MEM_CONSTS_SVH

// ====================
// message fields
// ====================

// byte address and data word widths
`define SEC_MEM_ADDR_NBITS 32
`define SEC_MEM_DATA_NBITS 32
// requester tag echoed back in every response
`define SEC_MEM_OPAQUE_NBITS 8

// ====================
// storage sizes
// ====================

// word count and the matching word index width
`define SEC_MEM_WORDS 64
`define SEC_MEM_IDX_NBITS 6
// entries in the response queue
`define SEC_MEM_QUEUE_DEPTH 2

`endif

//--- sec_mem_pkg.sv
// types shared by the security memory RTL and its testbench
// compile before any module that imports it
`include "sec_mem_consts.svh"

package sec_mem_pkg;

	// ====================
	// message fields
	// ====================

	// byte address into the bank
	typedef logic [`SEC_MEM_ADDR_NBITS-1:0] addr_t;
	// one data word
	typedef logic [`SEC_MEM_DATA_NBITS-1:0] data_t;
	// requester tag, returned untouched
	typedef logic [`SEC_MEM_OPAQUE_NBITS-1:0] opaque_t;
	// 0 is low, 1 is high
	typedef logic sec_level_t;

	// read or write request
	typedef enum logic {
		msg_read  = 1'b0,
		msg_write = 1'b1
	} mem_msg_type_t;

	// read and write pointer of the response queue
	typedef logic [$clog2(`SEC_MEM_QUEUE_DEPTH)-1:0] q_ptr_t;

endpackage

//--- sec_mem_subsys.sv
// security memory subsystem for one processor port
// request to bank, bank to response queue, queue to access filter
`timescale 1ns/1ps
`include "sec_mem_consts.svh"

module sec_mem_subsys import sec_mem_pkg::*; (
	input  logic          clk,
	input  logic          rst,
	// processor request
	input  logic          req_val,
	output logic          req_rdy,
	input  mem_msg_type_t req_type,
	input  addr_t         req_addr,
	input  data_t         req_data,
	input  opaque_t       req_opaque,
	input  sec_level_t    proc_sec_level,
	// processor response
	output logic          proc_resp_val,
	input  logic          proc_resp_rdy,
	output mem_msg_type_t proc_resp_type,
	output opaque_t       proc_resp_opaque,
	output data_t         proc_resp_data,
	output logic          proc_resp_fail
);
	// ====================
	// bank to queue
	// ====================
	logic          mresp_val;
	logic          mresp_rdy;
	mem_msg_type_t mresp_type;
	opaque_t       mresp_opaque;
	data_t         mresp_data;
	logic          mresp_fail;
	sec_level_t    mresp_sec_level;

	// ====================
	// queue to filter
	// ====================
	logic          qresp_val;
	logic          qresp_rdy;
	mem_msg_type_t qresp_type;
	opaque_t       qresp_opaque;
	data_t         qresp_data;
	logic          qresp_fail;
	sec_level_t    qresp_sec_level;

	mem_bank i_bank (
		.clk, .rst, .req_val, .req_rdy, .req_type, .req_addr, .req_data, .req_opaque,
		.proc_sec_level, .mresp_val, .mresp_rdy, .mresp_type, .mresp_opaque,
		.mresp_data, .mresp_fail, .mresp_sec_level
	);

	// absorbs processor back-pressure
	resp_queue i_queue (
		.clk, .rst, .mresp_val, .mresp_rdy, .mresp_type, .mresp_opaque, .mresp_data,
		.mresp_fail, .mresp_sec_level, .qresp_val, .qresp_rdy, .qresp_type,
		.qresp_opaque, .qresp_data, .qresp_fail, .qresp_sec_level
	);

	// level check against the same processor level the bank saw
	proc_resp_acc i_acc (
		.clk, .rst, .qresp_val, .qresp_rdy, .qresp_type, .qresp_opaque, .qresp_data,
		.qresp_fail, .qresp_sec_level, .proc_sec_level, .proc_resp_val, .proc_resp_rdy,
		.proc_resp_type, .proc_resp_opaque, .proc_resp_data, .proc_resp_fail
	);

endmodule

//--- tb_sec_mem_subsys.sv
// testbench for the security memory subsystem
// directed level checks, then a random burst under processor back-pressure
`timescale 1ns/1ps
`include "sec_mem_consts.svh"

module tb_sec_mem_subsys import sec_mem_pkg::*; ();
	logic          clk;
	logic          rst;
	logic          req_val;
	logic          req_rdy;
	mem_msg_type_t req_type;
	addr_t         req_addr;
	data_t         req_data;
	opaque_t       req_opaque;
	sec_level_t    proc_sec_level;
	logic          proc_resp_val;
	logic          proc_resp_rdy;
	mem_msg_type_t proc_resp_type;
	opaque_t       proc_resp_opaque;
	data_t         proc_resp_data;
	logic          proc_resp_fail;

	// shadow memory, plus a ring of expected responses in request order
	data_t         shadow_data [`SEC_MEM_WORDS];
	sec_level_t    shadow_tag  [`SEC_MEM_WORDS];
	mem_msg_type_t exp_type    [8];
	opaque_t       exp_opaque  [8];
	data_t         exp_data    [8];
	logic          exp_fail    [8];
	sec_level_t    exp_tag     [8];
	logic [31:0]   exp_head;
	logic [31:0]   exp_tail;
	logic [31:0]   outstanding;
	logic [2:0]    head;
	logic          hide;
	logic [15:0]   lfsr;
	logic          rdy_gaps;
	int            errors;
	int            stalls;

	sec_mem_subsys i_dut (.*);

	assign outstanding = exp_tail - exp_head;
	assign head = exp_head[2:0];
	// filter hides a high word from a low processor at delivery time
	assign hide = exp_tag[head] && !proc_sec_level;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Fibonacci LFSR, taps 16 14 13 11, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	// ====================
	// shadow model
	// ====================

	always @(posedge clk) begin
		logic [`SEC_MEM_IDX_NBITS-1:0] w;
		logic [2:0] slot;
		logic ok;
		w = req_addr[`SEC_MEM_IDX_NBITS+1:2];
		slot = exp_tail[2:0];
		ok = (req_addr < `SEC_MEM_WORDS * 4) && (req_addr[1:0] == 2'b00);
		if (rst) begin
			exp_head <= '0;
			exp_tail <= '0;
			for (int i = 0; i < `SEC_MEM_WORDS; i++) begin
				shadow_data[i] <= '0;
				shadow_tag[i]  <= 1'b0;
			end
		end else begin
			if (req_val && req_rdy) begin
				// bad address and refused write keep these defaults
				exp_type[slot]   <= req_type;
				exp_opaque[slot] <= req_opaque;
				exp_data[slot]   <= '0;
				exp_fail[slot]   <= 1'b1;
				exp_tag[slot]    <= 1'b0;
				if (ok && req_type == msg_read) begin
					exp_data[slot] <= shadow_data[w];
					exp_fail[slot] <= 1'b0;
					exp_tag[slot]  <= shadow_tag[w];
				end else if (ok && (proc_sec_level || !shadow_tag[w])) begin
					// allowed write, word takes the writer's level
					exp_fail[slot] <= 1'b0;
					exp_tag[slot]  <= proc_sec_level;
					shadow_data[w] <= req_data;
					shadow_tag[w]  <= proc_sec_level;
				end
				exp_tail <= exp_tail + 1;
			end
			if (proc_resp_val && proc_resp_rdy) begin
				exp_head <= exp_head + 1;
			end
			if (req_val && !req_rdy) begin
				stalls <= stalls + 1;
			end
		end
	end

	// processor stalls three cycles in four while gaps are on
	always @(negedge clk) begin
		proc_resp_rdy <= rdy_gaps ? (rand_bits(2) == 0) : 1'b1;
	end

	// ====================
	// checks
	// ====================

	// each delivered response matches the oldest expected one
	a_resp_match: assert property (@(posedge clk) disable iff (rst)
		proc_resp_val && proc_resp_rdy |-> outstanding != 0
			&& proc_resp_type == exp_type[head] && proc_resp_opaque == exp_opaque[head]
			&& proc_resp_data == (hide ? '0 : exp_data[head])
			&& proc_resp_fail == (exp_fail[head] || hide))
		else begin
			errors++;
			$display("error %0t: response opaque %0h differs from the model", $time,
				proc_resp_opaque);
		end

	// requests stall only once queue and bank register are all full
	a_rdy_full: assert property (@(posedge clk) disable iff (rst)
		req_rdy == (outstanding != `SEC_MEM_QUEUE_DEPTH + 1))
		else begin
			errors++;
			$display("error %0t: req_rdy %0b with %0d in flight", $time, req_rdy, outstanding);
		end

	// empty pipeline answers two cycles after the request
	a_latency: assert property (@(posedge clk) disable iff (rst)
		$past(req_val && req_rdy && outstanding == 0, 2) |-> proc_resp_val)
		else begin
			errors++;
			$display("error %0t: response late on an idle pipeline", $time);
		end

	// ====================
	// stimulus
	// ====================

	// drive one request and hold it until the bank takes it
	task automatic send(input mem_msg_type_t t, input addr_t a, input data_t d,
			input sec_level_t lvl);
		int waited;
		waited = 0;
		req_val = 1'b1;
		req_type = t;
		req_addr = a;
		req_data = d;
		proc_sec_level = lvl;
		req_opaque = req_opaque + 1'b1;
		while (!req_rdy && waited < 100) begin
			@(negedge clk);
			waited++;
		end
		if (!req_rdy) begin
			errors++;
			$display("request opaque %0h was never accepted", req_opaque);
		end
		@(negedge clk);
	endtask

	// wait for every outstanding response
	task automatic drain();
		int waited;
		waited = 0;
		req_val = 1'b0;
		while (outstanding != 0 && waited < 300) begin
			@(negedge clk);
			waited++;
		end
		if (outstanding != 0) begin
			errors++;
			$display("%0d responses never came back", outstanding);
		end
	endtask

	initial begin
		addr_t b_addr [20];
		data_t b_data [20];
		logic  b_wr   [20];
		logic  b_lvl  [20];
		lfsr = 16'd15;
		errors = 0;
		stalls = 0;
		rdy_gaps = 1'b0;
		rst = 1'b1;
		req_val = 1'b0;
		req_type = msg_read;
		req_addr = '0;
		req_data = '0;
		req_opaque = '0;
		proc_sec_level = 1'b0;
		proc_resp_rdy = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// the filter judges at delivery, so each read drains under its own level
		// same level round trips, low then high
		send(msg_write, 'h10, 'h1111_0010, 1'b0);
		send(msg_read, 'h10, '0, 1'b0);
		drain();
		send(msg_write, 'h20, 'h2222_0020, 1'b1);
		send(msg_read, 'h20, '0, 1'b1);
		drain();
		// high word hidden from a low reader, low word seen by a high one
		send(msg_write, 'h30, 'h3333_0030, 1'b1);
		send(msg_read, 'h30, '0, 1'b0);
		drain();
		send(msg_write, 'h40, 'h4444_0040, 1'b0);
		send(msg_read, 'h40, '0, 1'b1);
		drain();
		// low write onto a high word is refused, old data survives
		send(msg_write, 'h30, 'hdead_0030, 1'b0);
		send(msg_read, 'h30, '0, 1'b1);
		drain();
		// out of range and misaligned, then read the aliased words
		send(msg_write, 'h100, 'hbad0_0100, 1'b0);
		send(msg_write, 'h12, 'hbad0_0012, 1'b1);
		send(msg_read, 'h204, '0, 1'b1);
		send(msg_read, 'h0, '0, 1'b1);
		send(msg_read, 'h10, '0, 1'b1);
		drain();

		// burst drawn up front so only the stall generator steps the LFSR later
		for (int i = 0; i < 20; i++) begin
			b_wr[i] = rand_bits(1) != 0;
			b_lvl[i] = rand_bits(1) != 0;
			b_addr[i] = rand_bits(4) << 2;
			if (rand_bits(3) == 0) begin
				b_addr[i] = b_addr[i] + 32'h100;
			end
			if (rand_bits(3) == 0) begin
				b_addr[i] = b_addr[i] + 32'h2;
			end
			b_data[i] = rand_bits(32);
		end
		rdy_gaps = 1'b1;
		for (int i = 0; i < 20; i++) begin
			send(b_wr[i] ? msg_write : msg_read, b_addr[i], b_data[i], b_lvl[i]);
		end
		drain();
		rdy_gaps = 1'b0;
		if (stalls == 0) begin
			errors++;
			$display("back-pressure never filled the queue and the bank register");
		end

		$display("requests %0d, responses %0d, stalled cycles %0d, errors %0d",
			exp_tail, exp_head, stalls, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
